/* src/sd_pkg.sv */
// scan doubler constants
`default_nettype none

package sd_pkg;

	// bits per colour channel, half depth
	localparam int color_w = 4;

	// one stored pixel holds r, g and b
	localparam int pix_w = 3 * color_w;

	// entries per line buffer bank
	localparam int line_len = 256;

	// address within one bank
	localparam int addr_w = $clog2(line_len);

	// pixel period counter, in clk_vid cycles
	localparam int pcnt_w = 8;

	// clocks within one input line
	localparam int hcnt_w = 12;

endpackage

`default_nettype wire

/* src/sd_line_if.sv */
// line buffer access bus
`default_nettype none

interface sd_line_if;
	import sd_pkg::*;

	// write side, one input pixel per wr_en
	logic              wr_en;
	logic [addr_w-1:0] wr_addr;
	logic              wr_bank;
	logic [pix_w-1:0]  wr_data;

	// read side, data valid one clock after rd_en
	logic              rd_en;
	logic [addr_w-1:0] rd_addr;
	logic              rd_bank;
	logic [pix_w-1:0]  rd_data;

	modport ctrl (output wr_en, wr_addr, wr_bank, rd_en, rd_addr, rd_bank);

	// memory packs the colours onto wr_data itself
	modport mem (input wr_en, wr_addr, wr_bank, rd_en, rd_addr, rd_bank,
		output wr_data, rd_data);

endinterface

`default_nettype wire

/* src/pixel_rate.sv */
// pixel period and strobes
`default_nettype none

module pixel_rate (
	input  wire                         clk_vid,
	input  wire                         reset,
	input  wire                         ce_pix,
	input  wire                         hs_in,
	input  wire                         hb_in,
	input  wire                         vb_in,
	output logic                        ce_in,
	output logic                        ce_out,
	output logic [sd_pkg::pcnt_w-1:0]   pixsz
);
	import sd_pkg::*;

	logic [pcnt_w-1:0] pix_len;
	logic [pcnt_w-1:0] pix_in_cnt;
	logic [pcnt_w-1:0] pix_out_cnt;
	logic [pcnt_w-1:0] pl;
	logic [pcnt_w-1:0] pc_in;
	logic [pcnt_w-1:0] pc_out;
	logic [pcnt_w-1:0] pixsz2;
	logic              old_ce;
	logic              valid;
	logic              hs_d;
	logic              ce_rise;
	logic              hs_rise;

	assign pl      = pix_len + 1'b1;
	assign pc_in   = pix_in_cnt + 1'b1;
	assign pc_out  = pix_out_cnt + 1'b1;
	// output strobe lands mid period
	assign pixsz2  = {1'b0, pixsz[pcnt_w-1:1]};
	assign ce_rise = ~old_ce & ce_pix;
	assign hs_rise = ~hs_d & hs_in;

	always_ff @(posedge clk_vid) begin
		if (reset) begin
			pix_len     <= '0;
			pix_in_cnt  <= '0;
			pix_out_cnt <= '0;
			pixsz       <= '0;
			old_ce      <= 1'b0;
			valid       <= 1'b0;
			hs_d        <= 1'b0;
			ce_in       <= 1'b0;
			ce_out      <= 1'b0;
		end else begin
			// counters hold at all ones when no edge comes
			if (~&pix_len) pix_len <= pl;
			if (~&pix_in_cnt) pix_in_cnt <= pc_in;
			if (~&pix_out_cnt) pix_out_cnt <= pc_out;
			old_ce <= ce_pix;
			hs_d   <= hs_in;

			// period is only trusted between two active edges
			if (ce_rise) begin
				if (valid & ~hb_in & ~vb_in) pixsz <= pl;
				pix_len <= '0;
				valid   <= 1'b1;
			end
			if (hb_in | vb_in) valid <= 1'b0;

			// one input strobe per pixel, realigned by hsync
			ce_in <= 1'b0;
			if (hs_rise || pc_in >= pixsz) begin
				ce_in      <= 1'b1;
				pix_in_cnt <= '0;
			end

			// two output strobes per pixel
			ce_out <= 1'b0;
			if (pc_out == pixsz2) ce_out <= 1'b1;
			if (hs_rise || pc_out >= pixsz) begin
				ce_out      <= 1'b1;
				pix_out_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* src/line_timing.sv */
// doubled line timing control
`default_nettype none

module line_timing (
	input  wire                        clk_vid,
	input  wire                        reset,
	input  wire                        ce_in,
	input  wire                        ce_out,
	input  wire [sd_pkg::pcnt_w-1:0]   pixsz,
	input  wire                        hs_in,
	input  wire                        vs_in,
	input  wire                        hb_in,
	input  wire                        vb_in,
	sd_line_if.ctrl                    lb,
	output logic                       hs_out,
	output logic                       vs_out,
	output logic                       hb_out,
	output logic                       vb_out,
	output logic                       ce_pix_out
);
	import sd_pkg::*;

	logic                hs_d;
	logic                hb_d;
	logic                line_start;
	logic                out_start;
	logic [hcnt_w-1:0]   hcnt;
	// output counter and all positions are at half scale
	logic [hcnt_w-2:0]   sd_hcnt;
	logic [hcnt_w-2:0]   hs_start;
	logic [hcnt_w-2:0]   hs_end;
	logic [hcnt_w-2:0]   hde_start;
	logic [hcnt_w-2:0]   hde_end;
	logic                hb_o;
	logic                vs_s;
	logic                vb_s;
	logic                bank;
	logic [addr_w-1:0]   wr_cnt;
	logic [addr_w-1:0]   rd_cnt;

	// input line starts where blanking ends
	assign line_start = hb_d & ~hb_in;
	// second output line starts at half the input line
	assign out_start  = line_start | (sd_hcnt == hde_start);

	// write while the bank still has room
	assign lb.wr_en   = ce_in & ~hb_in & (wr_cnt != addr_w'(line_len - 1));
	assign lb.wr_addr = wr_cnt;
	assign lb.wr_bank = bank;
	// no reads until a pixel period is known
	assign lb.rd_en   = ce_out & ~hb_o & ~vb_out & (pixsz != '0);
	assign lb.rd_addr = rd_cnt;
	assign lb.rd_bank = ~bank;

	always_ff @(posedge clk_vid) begin
		if (reset) begin
			hs_d <= 1'b0;
			hb_d <= 1'b0;
			hcnt <= '0;
			sd_hcnt <= '0;
			hs_start <= '0;
			hs_end <= '0;
			hde_start <= '0;
			hde_end <= '0;
			hb_o <= 1'b0;
			vs_s <= 1'b0;
			vb_s <= 1'b0;
			bank <= 1'b0;
			wr_cnt <= '0;
			rd_cnt <= '0;
			hs_out <= 1'b0;
			vs_out <= 1'b0;
			hb_out <= 1'b0;
			vb_out <= 1'b0;
			ce_pix_out <= 1'b0;
		end else begin
			hs_d    <= hs_in;
			hb_d    <= hb_in;
			hcnt    <= hcnt + 1'b1;
			sd_hcnt <= sd_hcnt + 1'b1;

			// output line start opens active video and rewinds the read
			if (out_start) begin
				sd_hcnt <= '0;
				hb_o    <= 1'b0;
				rd_cnt  <= '0;
			end else if (lb.rd_en) begin
				rd_cnt <= rd_cnt + 1'b1;
			end
			// stays blank while positions are still unmeasured
			if (sd_hcnt == hde_end) hb_o <= 1'b1;

			// hsync replayed twice per input line
			if (sd_hcnt == hs_start) hs_out <= 1'b1;
			if (sd_hcnt == hs_end) hs_out <= 1'b0;

			// input line start swaps banks and steps the vertical delay
			if (line_start) begin
				hcnt      <= '0;
				hde_start <= hcnt[hcnt_w-1:1];
				bank      <= ~bank;
				wr_cnt    <= '0;
				vs_s      <= vs_in;
				vs_out    <= vs_s;
				vb_s      <= vb_in;
				vb_out    <= vb_s;
			end else if (lb.wr_en) begin
				wr_cnt <= wr_cnt + 1'b1;
			end

			// halved edge positions from this line
			if (~hb_d & hb_in) hde_end <= hcnt[hcnt_w-1:1];
			if (~hs_d & hs_in) hs_start <= hcnt[hcnt_w-1:1];
			if (hs_d & ~hs_in) hs_end <= hcnt[hcnt_w-1:1];

			// matched to the registered read data
			hb_out     <= hb_o;
			ce_pix_out <= lb.rd_en;
		end
	end

endmodule

`default_nettype wire

/* src/line_buffer.sv */
// two bank line memory
`default_nettype none

module line_buffer (
	input  wire                        clk_vid,
	sd_line_if.mem                     lb,
	input  wire [sd_pkg::color_w-1:0]  r_in,
	input  wire [sd_pkg::color_w-1:0]  g_in,
	input  wire [sd_pkg::color_w-1:0]  b_in
);
	import sd_pkg::*;

	// bank select is the top address bit
	logic [pix_w-1:0] mem [0:2*line_len-1];
	logic [addr_w:0]  wr_ptr;
	logic [addr_w:0]  rd_ptr;

	// pixel word is r in the top bits, then g, then b
	assign lb.wr_data = {r_in, g_in, b_in};

	assign wr_ptr = {lb.wr_bank, lb.wr_addr};
	assign rd_ptr = {lb.rd_bank, lb.rd_addr};

	// colours hold for the whole input pixel, so the write
	// strobe can sit anywhere inside it
	always_ff @(posedge clk_vid) begin
		if (lb.wr_en) begin
			mem[wr_ptr] <= lb.wr_data;
		end
	end

	// registered read port
	// rd_data keeps the last pixel between strobes
	always_ff @(posedge clk_vid) begin
		if (lb.rd_en) begin
			lb.rd_data <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

/* src/scandoubler.sv */
// video scan doubler top
`default_nettype none

module scandoubler (
	input  wire                        clk_vid,
	input  wire                        reset,
	input  wire                        ce_pix,
	input  wire                        hs_in,
	input  wire                        vs_in,
	input  wire                        hb_in,
	input  wire                        vb_in,
	input  wire [sd_pkg::color_w-1:0]  r_in,
	input  wire [sd_pkg::color_w-1:0]  g_in,
	input  wire [sd_pkg::color_w-1:0]  b_in,
	output logic                       ce_pix_out,
	output logic                       hs_out,
	output logic                       vs_out,
	output logic                       hb_out,
	output logic                       vb_out,
	output logic [sd_pkg::color_w-1:0] r_out,
	output logic [sd_pkg::color_w-1:0] g_out,
	output logic [sd_pkg::color_w-1:0] b_out
);
	import sd_pkg::*;

	logic              ce_in;
	logic              ce_out;
	logic [pcnt_w-1:0] pixsz;

	sd_line_if lb ();

	// input and doubled pixel strobes
	pixel_rate u_pixel_rate (
		.clk_vid (clk_vid),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.hs_in   (hs_in),
		.hb_in   (hb_in),
		.vb_in   (vb_in),
		.ce_in   (ce_in),
		.ce_out  (ce_out),
		.pixsz   (pixsz)
	);

	line_timing u_line_timing (
		.clk_vid    (clk_vid),
		.reset      (reset),
		.ce_in      (ce_in),
		.ce_out     (ce_out),
		.pixsz      (pixsz),
		.hs_in      (hs_in),
		.vs_in      (vs_in),
		.hb_in      (hb_in),
		.vb_in      (vb_in),
		.lb         (lb),
		.hs_out     (hs_out),
		.vs_out     (vs_out),
		.hb_out     (hb_out),
		.vb_out     (vb_out),
		.ce_pix_out (ce_pix_out)
	);

	line_buffer u_line_buffer (
		.clk_vid (clk_vid),
		.lb      (lb),
		.r_in    (r_in),
		.g_in    (g_in),
		.b_in    (b_in)
	);

	// same packing as the write side
	assign {r_out, g_out, b_out} = lb.rd_data;

endmodule

`default_nettype wire

/* tb/sd_checker.sv */
// scan doubler output checker
`default_nettype none

module sd_checker #(
	parameter int act_pix   = 200,
	parameter int act_lines = 16,
	parameter int frames    = 3
) (
	input  wire                        clk_vid,
	input  wire                        reset,
	input  wire                        done,
	input  wire                        hb_in,
	input  wire                        vb_in,
	input  wire                        ce_pix_out,
	input  wire                        hs_out,
	input  wire                        vs_out,
	input  wire                        hb_out,
	input  wire                        vb_out,
	input  wire [sd_pkg::color_w-1:0]  r_out,
	input  wire [sd_pkg::color_w-1:0]  g_out,
	input  wire [sd_pkg::color_w-1:0]  b_out,
	output int                         errors,
	output int                         pixels
);
	timeunit 1ns;
	timeprecision 1ps;
	import sd_pkg::*;

	logic reset_d, hb_in_d, hs_out_d, hb_out_d, vb_out_d, vs_out_d, done_d;
	bit   fall_seen;
	int   act_cnt, cur_id, prev_id, exp_line, col, line_n;
	int   hs_rises, hb_falls, vert_lines, vert_checks, vs_rises;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// expected pixel, r in the top bits, one lfsr step per bit
	function automatic logic [pix_w-1:0] ref_pixel(input int line, input int col_i);
		logic [31:0]      s;
		logic [pix_w-1:0] px;
		s = 32'h1638 ^ (line << 16) ^ col_i;
		for (int i = pix_w - 1; i >= 0; i--) begin
			s = lfsr_next(s);
			px[i] = s[0];
		end
		return px;
	endfunction

	task automatic value_error(input string name, input int got, input int exp);
		$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
		errors = errors + 1;
	endtask

	initial begin
		errors = 0;
		pixels = 0;
		act_cnt = 0;
		cur_id = -1;
		prev_id = -1;
		exp_line = -1;
		col = 0;
		line_n = 0;
		hs_rises = 0;
		hb_falls = 0;
		vert_lines = 0;
		vert_checks = 0;
		vs_rises = 0;
		fall_seen = 0;
	end

	always @(posedge clk_vid) begin
		logic [pix_w-1:0] exp_px;
		// registered outputs must hold their reset values
		if (reset_d && (ce_pix_out | hs_out | vs_out | hb_out | vb_out)) begin
			$display("control outputs are not low during reset at %0t", $time);
			errors = errors + 1;
		end
		if (!reset) begin
			// two syncs per input line once the first line has set the positions
			if (hb_in_d && !hb_in) begin
				if (line_n >= 3) begin
					if (hs_rises != 2) value_error("hs_out", hs_rises, 2);
					if (hb_falls != 2) value_error("hb_out", hb_falls, 2);
				end
				hs_rises = 0;
				hb_falls = 0;
				line_n++;
				prev_id = cur_id;
				cur_id = vb_in ? -1 : act_cnt;
				if (!vb_in) act_cnt++;
			end
			if (!hs_out_d && hs_out) hs_rises++;
			if (vb_out_d && !vb_out) begin
				fall_seen = 1;
				vert_lines = 0;
			end
			if (!vb_out_d && vb_out && fall_seen) begin
				if (vert_lines != 2 * act_lines)
					value_error("vb_out", vert_lines, 2 * act_lines);
				vert_checks++;
			end
			if (!vs_out_d && vs_out) vs_rises++;
			// output line start reads the previous input line from column 0
			if (hb_out_d && !hb_out) begin
				hb_falls++;
				exp_line = prev_id;
				col = 0;
				if (!vb_out) vert_lines++;
			end
			// the first stored line is skipped while the period settles
			if (ce_pix_out && !hb_out && !vb_out && exp_line >= 1) begin
				exp_px = ref_pixel(exp_line, col);
				if (r_out !== exp_px[pix_w-1 -: color_w])
					value_error("r_out", r_out, exp_px[pix_w-1 -: color_w]);
				if (g_out !== exp_px[2*color_w-1 -: color_w])
					value_error("g_out", g_out, exp_px[2*color_w-1 -: color_w]);
				if (b_out !== exp_px[color_w-1:0])
					value_error("b_out", b_out, exp_px[color_w-1:0]);
				col++;
				pixels++;
			end
			if (!hb_out_d && hb_out && exp_line >= 1) begin
				if (col != act_pix) value_error("ce_pix_out", col, act_pix);
				exp_line = -1;
			end
		end
		// end of run totals
		if (done && !done_d) begin
			if (vs_rises != frames) value_error("vs_out", vs_rises, frames);
			if (vert_checks != frames - 1) begin
				$display("vertical blanking was measured in too few frames");
				errors = errors + 1;
			end
		end
		reset_d = reset;
		hb_in_d = hb_in;
		hs_out_d = hs_out;
		hb_out_d = hb_out;
		vb_out_d = vb_out;
		vs_out_d = vs_out;
		done_d = done;
	end

endmodule

`default_nettype wire

/* tb/sd_sva.sv */
// line timing assertions
`default_nettype none

module sd_sva (
	input wire clk_vid,
	input wire reset,
	input wire hb_in,
	input wire ce_in,
	input wire ce_out,
	input wire ce_pix_out,
	input wire hs_out,
	input wire vs_out,
	input wire hb_out,
	input wire vb_out,
	input wire wr_en,
	input wire rd_en,
	input wire wr_bank,
	input wire rd_bank
);
	timeunit 1ns;
	timeprecision 1ps;

	// no output pixel inside horizontal blanking
	a_pix_blank: assert property (@(posedge clk_vid) disable iff (reset)
		ce_pix_out |-> !hb_out) else $error("ce_pix_out during hb_out");

	// banks swap only at an input line start and the read side takes the bank just written
	a_banks: assert property (@(posedge clk_vid) disable iff (reset)
		$changed(wr_bank) |-> $past(hb_in, 2) && !$past(hb_in)
			&& rd_bank == $past(wr_bank))
		else $error("wr_bank and rd_bank did not swap at a line start");

	// strobes and controls low in reset and the clock after
	a_reset: assert property (@(posedge clk_vid)
		reset |=> !(ce_in | ce_out | ce_pix_out | hs_out | vs_out | hb_out | vb_out
			| wr_en | rd_en)) else $error("outputs active after reset");

endmodule

// ce_in and ce_out arrive here from pixel_rate
bind line_timing sd_sva sva_i (
	.clk_vid    (clk_vid),
	.reset      (reset),
	.hb_in      (hb_in),
	.ce_in      (ce_in),
	.ce_out     (ce_out),
	.ce_pix_out (ce_pix_out),
	.hs_out     (hs_out),
	.vs_out     (vs_out),
	.hb_out     (hb_out),
	.vb_out     (vb_out),
	.wr_en      (lb.wr_en),
	.rd_en      (lb.rd_en),
	.wr_bank    (lb.wr_bank),
	.rd_bank    (lb.rd_bank)
);

`default_nettype wire

/* tb/tb_scandoubler.sv */
// scan doubler testbench
`default_nettype none

module tb_scandoubler;
	timeunit 1ns;
	timeprecision 1ps;
	import sd_pkg::*;

	// pixel period in clocks and the video geometry
	localparam int pix_period = 8;
	localparam int act_pix    = 200;
	localparam int line_pix   = 260;
	localparam int hs_first   = 210;
	localparam int hs_last    = 230;
	localparam int act_lines  = 16;
	localparam int frame_ln   = 20;
	localparam int frames     = 3;
	localparam int frame_clks = frame_ln * line_pix * pix_period;
	// three frames plus ten percent
	localparam int timeout_lim = frame_clks * frames + frame_clks * frames / 10;

	logic clk_vid, reset, done, ce_pix, hs_in, vs_in, hb_in, vb_in;
	logic [color_w-1:0] r_in, g_in, b_in, r_out, g_out, b_out;
	logic ce_pix_out, hs_out, vs_out, hb_out, vb_out;
	int   chk_errors, pixels, cycles;

	scandoubler dut_i (.*);

	sd_checker #(.act_pix(act_pix), .act_lines(act_lines), .frames(frames)) chk_i (
		.clk_vid(clk_vid), .reset(reset), .done(done), .hb_in(hb_in), .vb_in(vb_in),
		.ce_pix_out(ce_pix_out), .hs_out(hs_out), .vs_out(vs_out), .hb_out(hb_out),
		.vb_out(vb_out), .r_out(r_out), .g_out(g_out), .b_out(b_out),
		.errors(chk_errors), .pixels(pixels)
	);

	initial clk_vid = 1'b0;
	always #2 clk_vid = ~clk_vid;

	// one input pixel, ce_pix high for its first clock
	task automatic send_pixel(input logic hb, input logic hs, input logic vb,
		input logic vs, input logic [pix_w-1:0] px);
		@(negedge clk_vid);
		ce_pix = 1'b1;
		hb_in = hb;
		hs_in = hs;
		vb_in = vb;
		vs_in = vs;
		{r_in, g_in, b_in} = px;
		repeat (pix_period - 1) begin
			@(negedge clk_vid);
			ce_pix = 1'b0;
		end
	endtask

	always @(posedge clk_vid) begin
		cycles++;
		if (cycles >= timeout_lim) begin
			$display("timeout after %0d clock cycles, run stopped", cycles);
			$display("errors: checker %0d, timeout 1", chk_errors);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		int g;
		int errs;
		reset = 1'b1;
		done = 1'b0;
		ce_pix = 1'b0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		hb_in = 1'b1;
		vb_in = 1'b0;
		{r_in, g_in, b_in} = '0;
		cycles = 0;
		g = 0;
		repeat (2) @(posedge clk_vid);
		@(negedge clk_vid);
		reset = 1'b0;
		// active lines first, then vertical blank with vsync on line 17
		for (int f = 0; f < frames; f++) begin
			for (int ln = 0; ln < frame_ln; ln++) begin
				for (int px = 0; px < line_pix; px++) begin
					send_pixel(px >= act_pix, px >= hs_first && px < hs_last,
						ln >= act_lines, ln == act_lines + 1,
						(ln < act_lines && px < act_pix) ? chk_i.ref_pixel(g, px) : '0);
				end
				if (ln < act_lines) g++;
			end
		end
		repeat (200) @(negedge clk_vid);
		done = 1'b1;
		repeat (2) @(negedge clk_vid);
		errs = chk_errors;
		if (pixels == 0) begin
			$display("no output pixels were compared");
			errs++;
		end
		$display("errors: checker %0d, timeout 0, pixels checked %0d", errs, pixels);
		if (errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
src/sd_pkg.sv
src/sd_line_if.sv
src/pixel_rate.sv
src/line_timing.sv
src/line_buffer.sv
src/scandoubler.sv
tb/sd_checker.sv
tb/sd_sva.sv
tb/tb_scandoubler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scandoubler
FLIST     ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
